//--- Makefile
TOP := tcm_tb

all: run

build:
	verilator --binary --assert --timescale 1ns/100ps -f tb.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	@grep -q "^Test passed$$" sim.log

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- rtl/tcm_credit_buffer.sv
// input fifo with credit return to the sender and output credit gate toward the chain

`timescale 1ns/100ps

`include "tcm_settings.svh"

module tcm_credit_buffer (
  input  logic                   iclk,
  input  logic                   ireset,
  // sender side
  input  logic                   in_val,
  input  logic                   in_sop,
  input  logic                   in_eop,
  input  logic [`TCM_TAG_W-1:0]  in_tag,
  input  logic [3:1]             in_dat,
  output logic                   in_credit,
  // sink credit return
  input  logic                   out_credit,
  // release toward encoder
  output logic                   rel_val,
  output logic                   rel_sop,
  output logic                   rel_eop,
  output logic [`TCM_TAG_W-1:0]  rel_tag,
  output logic [3:1]             rel_dat
);

  localparam int DEPTH  = `TCM_IN_DEPTH;
  localparam int CREDS  = `TCM_OUT_CREDITS;
  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int CRED_W = $clog2(CREDS + 1);
  localparam int ENTRY_W = `TCM_TAG_W + 5;  // sop, eop, tag, 3 data bits

  ////////////////////////////////////////
  // storage and control state
  logic [ENTRY_W-1:0] mem [DEPTH];          // payload only, no reset
  logic [ADDR_W-1:0]  wr_ptr;
  logic [ADDR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]   fifo_cnt;             // entries held
  logic [CRED_W-1:0]  cred_cnt;             // output credits on hand
  logic               do_rel;
  logic [ENTRY_W-1:0] rd_entry;

  // release whenever something is held and the sink has room for it
  assign do_rel   = (fifo_cnt != '0) && (cred_cnt != '0);
  assign rd_entry = mem[rd_ptr];

  // credit back to sender one cycle after the release edge
  assign in_credit = rel_val;

  ////////////////////////////////////////
  // fifo write side
  always_ff @(posedge iclk) begin
    if (in_val) begin
      mem[wr_ptr] <= {in_sop, in_eop, in_tag, in_dat};
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (in_val) begin
        wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
      end
      if (do_rel) begin
        rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // occupancy, write and release may land on the same edge
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      fifo_cnt <= '0;
    end else begin
      case ({in_val, do_rel})
        2'b10   : fifo_cnt <= fifo_cnt + 1'b1;
        2'b01   : fifo_cnt <= fifo_cnt - 1'b1;
        default : fifo_cnt <= fifo_cnt;     // both or none
      endcase
    end
  end

  ////////////////////////////////////////
  // output credit counter
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cred_cnt <= CRED_W'(CREDS);
    end else begin
      case ({do_rel, out_credit})
        2'b10   : cred_cnt <= cred_cnt - 1'b1;  // spent on release
        2'b01   : cred_cnt <= cred_cnt + 1'b1;  // sink gave one back
        default : cred_cnt <= cred_cnt;
      endcase
    end
  end

  ////////////////////////////////////////
  // release register
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rel_val <= 1'b0;
    end else begin
      rel_val <= do_rel;
    end
  end

  always_ff @(posedge iclk) begin
    if (do_rel) begin
      {rel_sop, rel_eop, rel_tag, rel_dat} <= rd_entry;
    end
  end

  ////////////////////////////////////////
  // checks
  // sender overran its input credits
  a_no_write_full : assert property (@(posedge iclk) disable iff (ireset)
    in_val |-> (fifo_cnt != CNT_W'(DEPTH)));

  // sink returned a credit while the counter was already full
  a_cred_max : assert property (@(posedge iclk) disable iff (ireset)
    (out_credit && !do_rel) |-> (cred_cnt != CRED_W'(CREDS)));

endmodule

//--- rtl/tcm_pkg.sv
// tcm types and helpers: code word views, qam level type, trellis and gray rules

package tcm_pkg;

  ////////////////////////////////////////
  // code word, written raw by the encoder and read as point/subset by the mapper
  typedef union packed {
    logic [3:0] raw;          // {dat[3:1], state bit 0}
    struct packed {
      logic [1:0] point;      // uncoded bits 3..2
      logic [1:0] subset;     // coded bit 1 plus state bit
    } qam;
  } code_word_u;

  // one axis amplitude, -3 / -1 / +1 / +3
  typedef logic signed [2:0] level_t;

  ////////////////////////////////////////
  // 4 state trellis, only input bit 1 feeds the state
  function automatic logic [1:0] trellis_next(input logic [1:0] state,
                                              input logic [3:1] sym);
    logic [1:0] nxt;
    nxt[1] = state[0] ^ sym[1];
    nxt[0] = state[1];          // plain shift of old bit 1
    return nxt;
  endfunction

  // gray coded 2 bit -> axis level
  function automatic level_t gray_level(input logic [1:0] bits);
    level_t lvl;
    case (bits)
      2'b00   : lvl = -3'sd3;
      2'b01   : lvl = -3'sd1;
      2'b11   : lvl =  3'sd1;
      default : lvl =  3'sd3;   // 2'b10
    endcase
    return lvl;
  endfunction

endpackage

//--- rtl/tcm_qam16_mapper.sv
// 16-qam mapper stage, code word split into subset and point, gray levels on I and Q

`timescale 1ns/100ps

`include "tcm_settings.svh"

module tcm_qam16_mapper
  import tcm_pkg::*;
(
  input  logic                   iclk,
  input  logic                   ireset,
  // from encoder
  input  logic                   enc_val,
  input  logic                   enc_sop,
  input  logic                   enc_eop,
  input  logic [`TCM_TAG_W-1:0]  enc_tag,
  input  code_word_u             enc_word,
  // chain output
  output logic                   out_val,
  output logic                   out_sop,
  output logic                   out_eop,
  output logic [`TCM_TAG_W-1:0]  out_tag,
  output level_t                 out_i,
  output level_t                 out_q
);

  logic [1:0] i_bits;   // {point msb, subset msb}
  logic [1:0] q_bits;   // {point lsb, subset lsb}

  // subset picks within a quadrant, point picks the quadrant
  assign i_bits = {enc_word.qam.point[1], enc_word.qam.subset[1]};
  assign q_bits = {enc_word.qam.point[0], enc_word.qam.subset[0]};

  ////////////////////////////////////////
  // valid
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      out_val <= 1'b0;
    end else begin
      out_val <= enc_val;
    end
  end

  ////////////////////////////////////////
  // levels and markers
  always_ff @(posedge iclk) begin
    if (enc_val) begin
      out_sop <= enc_sop;
      out_eop <= enc_eop;
      out_tag <= enc_tag;
      out_i   <= gray_level(i_bits);
      out_q   <= gray_level(q_bits);
    end
  end

endmodule

//--- rtl/tcm_settings.svh
// tcm tx chain settings: tag width, input buffer depth and output credit count

`ifndef TCM_SETTINGS_SVH
`define TCM_SETTINGS_SVH

////////////////////////////////////////
// frame markers
`define TCM_TAG_W        4   // frame tag width

////////////////////////////////////////
// flow control
`define TCM_IN_DEPTH     4   // input fifo entries, also sender start credits
`define TCM_OUT_CREDITS  3   // max symbols released but not yet acked by sink

`endif

//--- rtl/tcm_trellis_enc.sv
// rate 3/4 trellis encoder stage, 4 states restarted at sop, tag held per frame

`timescale 1ns/100ps

`include "tcm_settings.svh"

module tcm_trellis_enc
  import tcm_pkg::*;
(
  input  logic                   iclk,
  input  logic                   ireset,
  // from buffer
  input  logic                   rel_val,
  input  logic                   rel_sop,
  input  logic                   rel_eop,
  input  logic [`TCM_TAG_W-1:0]  rel_tag,
  input  logic [3:1]             rel_dat,
  // to mapper
  output logic                   enc_val,
  output logic                   enc_sop,
  output logic                   enc_eop,
  output logic [`TCM_TAG_W-1:0]  enc_tag,
  output code_word_u             enc_word
);

  logic [1:0] state;       // trellis state between symbols
  logic [1:0] cur_state;   // state the current symbol is coded from

  // a new frame always starts at state 0
  assign cur_state = rel_sop ? 2'b00 : state;

  ////////////////////////////////////////
  // control: valid and trellis state
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      enc_val <= 1'b0;
      state   <= 2'b00;
    end else begin
      enc_val <= rel_val;
      if (rel_val) begin
        state <= trellis_next(cur_state, rel_dat);
      end
    end
  end

  ////////////////////////////////////////
  // payload: markers, tag and code word
  always_ff @(posedge iclk) begin
    if (rel_val) begin
      enc_sop      <= rel_sop;
      enc_eop      <= rel_eop;
      enc_word.raw <= {rel_dat, cur_state[0]};  // 3 bits through + 1 state bit
      if (rel_sop) begin
        enc_tag <= rel_tag;                     // held till next sop
      end
    end
  end

endmodule

//--- rtl/tcm_tx_top.sv
// tcm transmit chain top: credit buffer, trellis encoder and 16-qam mapper in series

`timescale 1ns/100ps

`include "tcm_settings.svh"

module tcm_tx_top
  import tcm_pkg::*;
(
  input  logic                   iclk,
  input  logic                   ireset,
  // sender side
  input  logic                   in_val,
  input  logic                   in_sop,
  input  logic                   in_eop,
  input  logic [`TCM_TAG_W-1:0]  in_tag,
  input  logic [3:1]             in_dat,
  output logic                   in_credit,
  // sink side
  output logic                   out_val,
  output logic                   out_sop,
  output logic                   out_eop,
  output logic [`TCM_TAG_W-1:0]  out_tag,
  output level_t                 out_i,
  output level_t                 out_q,
  input  logic                   out_credit
);

  ////////////////////////////////////////
  // stage links, no back-pressure inside
  logic                  rel_val;
  logic                  rel_sop;
  logic                  rel_eop;
  logic [`TCM_TAG_W-1:0] rel_tag;
  logic [3:1]            rel_dat;

  logic                  enc_val;
  logic                  enc_sop;
  logic                  enc_eop;
  logic [`TCM_TAG_W-1:0] enc_tag;
  code_word_u            enc_word;

  // buffer and credit gate
  tcm_credit_buffer u_buf (
    .iclk       (iclk),
    .ireset     (ireset),
    .in_val     (in_val),
    .in_sop     (in_sop),
    .in_eop     (in_eop),
    .in_tag     (in_tag),
    .in_dat     (in_dat),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .rel_val    (rel_val),
    .rel_sop    (rel_sop),
    .rel_eop    (rel_eop),
    .rel_tag    (rel_tag),
    .rel_dat    (rel_dat)
  );

  // trellis coder, one cycle
  tcm_trellis_enc u_enc (
    .iclk     (iclk),
    .ireset   (ireset),
    .rel_val  (rel_val),
    .rel_sop  (rel_sop),
    .rel_eop  (rel_eop),
    .rel_tag  (rel_tag),
    .rel_dat  (rel_dat),
    .enc_val  (enc_val),
    .enc_sop  (enc_sop),
    .enc_eop  (enc_eop),
    .enc_tag  (enc_tag),
    .enc_word (enc_word)
  );

  // qam mapper, one cycle
  tcm_qam16_mapper u_map (
    .iclk     (iclk),
    .ireset   (ireset),
    .enc_val  (enc_val),
    .enc_sop  (enc_sop),
    .enc_eop  (enc_eop),
    .enc_tag  (enc_tag),
    .enc_word (enc_word),
    .out_val  (out_val),
    .out_sop  (out_sop),
    .out_eop  (out_eop),
    .out_tag  (out_tag),
    .out_i    (out_i),
    .out_q    (out_q)
  );

endmodule

//--- sim/tcm_tb.sv
// tcm tx chain testbench with a credit-obeying sender, a delayed credit sink and a reference model

`timescale 1ns/100ps

`include "tcm_settings.svh"

module tcm_tb
  import tcm_pkg::*;
();

  localparam int TW      = `TCM_TAG_W;
  localparam int EXP_W   = TW + 11;        // {hold, sop, eop, tag, i, q}
  localparam int TIMEOUT = 200;            // cycles allowed per wait
  localparam int NROWS   = 8;

  // one row per frame {tag, length, sink hold}
  localparam logic [11:0] ROWS [NROWS] = '{
    12'h1_3_0, 12'h2_1_0, 12'h7_9_2, 12'ha_5_5,
    12'h5_2_1, 12'hc_7_0, 12'h3_4_3, 12'hf_6_4
  };

  logic           iclk;
  logic           ireset;
  logic           in_val;
  logic           in_sop;
  logic           in_eop;
  logic [TW-1:0]  in_tag;
  logic [3:1]     in_dat;
  logic           in_credit;
  logic           out_val;
  logic           out_sop;
  logic           out_eop;
  logic [TW-1:0]  out_tag;
  level_t         out_i;
  level_t         out_q;
  logic           out_credit;

  logic [EXP_W-1:0] exp_q [$];     // model output, in send order
  logic [2:0]       hold_q [$];    // sink hold for each received symbol

  int in_creds   = `TCM_IN_DEPTH;  // sender side credit count
  int sent_cnt   = 0;
  int crd_pulses = 0;              // in_credit pulses seen
  int rcv_cnt    = 0;
  int ret_cnt    = 0;              // out_credit pulses given
  int value_errs = 0;
  int other_errs = 0;

  tcm_tx_top dut (
    .iclk       (iclk),
    .ireset     (ireset),
    .in_val     (in_val),
    .in_sop     (in_sop),
    .in_eop     (in_eop),
    .in_tag     (in_tag),
    .in_dat     (in_dat),
    .in_credit  (in_credit),
    .out_val    (out_val),
    .out_sop    (out_sop),
    .out_eop    (out_eop),
    .out_tag    (out_tag),
    .out_i      (out_i),
    .out_q      (out_q),
    .out_credit (out_credit)
  );

  initial begin
    iclk = 1'b0;
    forever #20 iclk = ~iclk;     // 40 ns period
  end

  ////////////////////////////////////////
  // model helpers
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 4 state trellis, data bit 1 feeds state bit 1, old bit 1 shifts down
  function automatic logic [1:0] next_state(input logic [1:0] st, input logic [3:1] d);
    return {st[0] ^ d[1], st[1]};
  endfunction

  // gray order along one axis
  function automatic logic signed [2:0] axis_level(input logic [1:0] b);
    case (b)
      2'b00   : return -3'sd3;
      2'b01   : return -3'sd1;
      2'b11   : return 3'sd1;
      default : return 3'sd3;
    endcase
  endfunction

  function automatic int frame_total();
    int t;
    t = 0;
    for (int r = 0; r < NROWS; r++) begin
      t += int'(ROWS[r][7:4]);
    end
    return t;
  endfunction

  ////////////////////////////////////////
  // reporting
  task automatic check_value(input string name, input logic signed [31:0] exp,
                             input logic signed [31:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic finish_run(input bit timed_out);
    $display("value errors %0d, other errors %0d, timeouts %0d",
             value_errs, other_errs, int'(timed_out));
    if (!timed_out && value_errs == 0 && other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    finish_run(1'b1);
  endtask

  ////////////////////////////////////////
  // monitor, samples everything on the rising edge
  always @(posedge iclk) begin
    logic [EXP_W-1:0] e;
    if (!ireset) begin
      if (sent_cnt == 0 && (out_val !== 1'b0 || in_credit !== 1'b0)) begin
        other_errs++;
        $display("activity on out_val or in_credit at %0t before any symbol", $time);
      end
      if (in_val) begin
        if (in_creds == 0) begin
          other_errs++;
          $display("sender sent at %0t without an input credit", $time);
        end
        in_creds--;
        sent_cnt++;
      end
      if (in_credit) begin
        in_creds++;
        crd_pulses++;
      end
      if (in_creds > `TCM_IN_DEPTH) begin
        other_errs++;
        $display("more input credits returned than spent at %0t", $time);
      end
      if (out_val) begin
        rcv_cnt++;
        if (exp_q.size() == 0) begin
          other_errs++;
          $display("extra output symbol at %0t with nothing expected", $time);
        end else begin
          e = exp_q.pop_front();
          check_value("out_sop", 32'(e[TW+7]), 32'(out_sop));
          check_value("out_eop", 32'(e[TW+6]), 32'(out_eop));
          check_value("out_tag", 32'(e[TW+5:6]), 32'(out_tag));
          check_value("out_i", 32'($signed(e[5:3])), 32'(out_i));
          check_value("out_q", 32'($signed(e[2:0])), 32'(out_q));
          hold_q.push_back(e[TW+10:TW+8]);
        end
      end
      if (out_credit) ret_cnt++;
      if (rcv_cnt - ret_cnt > `TCM_OUT_CREDITS) begin
        other_errs++;
        $display("%0d symbols outstanding at %0t", rcv_cnt - ret_cnt, $time);
      end
    end
  end

  ////////////////////////////////////////
  // sink, one credit per symbol after its row's hold time
  initial begin : credit_return
    int w;
    int n;
    bit stuck;
    logic [2:0] h;
    out_credit = 1'b0;
    n          = 0;
    stuck      = 1'b0;
    while (n < frame_total() && !stuck) begin
      w = 0;
      while (hold_q.size() == 0 && w < TIMEOUT) begin
        out_credit = 1'b0;
        @(posedge iclk);
        #1;
        w++;
      end
      if (hold_q.size() == 0) begin
        stuck = 1'b1;
      end else begin
        h = hold_q.pop_front();
        out_credit = 1'b0;
        for (w = 0; w < int'(h); w++) begin
          @(posedge iclk);
          #1;
        end
        out_credit = 1'b1;                // one cycle pulse
        @(posedge iclk);
        #1;
        n++;
      end
    end
    out_credit = 1'b0;
    if (stuck) begin
      report_timeout("a symbol at the sink");
    end
  end

  ////////////////////////////////////////
  // sender and model
  initial begin
    int len;
    int w;
    int total;
    bit stuck;
    logic [31:0]       rng;
    logic [1:0]        st;       // model trellis state
    logic [3:1]        dat;
    logic [TW-1:0]     tag;
    logic [2:0]        hold;
    logic              sop;
    logic              eop;
    logic signed [2:0] i_exp;
    logic signed [2:0] q_exp;
    $timeformat(-9, 1, " ns", 0);
    in_val = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
    in_tag = '0;
    in_dat = '0;
    ireset = 1'b1;
    rng    = 32'd87;
    st     = 2'b00;
    stuck  = 1'b0;
    total  = frame_total();
    repeat (2) @(posedge iclk);
    #1;
    ireset = 1'b0;
    for (w = 0; w < 4; w++) begin
      @(posedge iclk);                     // quiet after reset, nothing sent yet
    end
    #1;
    for (int r = 0; r < NROWS && !stuck; r++) begin
      tag  = ROWS[r][TW+7:8];
      len  = int'(ROWS[r][7:4]);
      hold = ROWS[r][2:0];
      for (int s = 0; s < len && !stuck; s++) begin
        w = 0;
        while (in_creds == 0 && w < TIMEOUT) begin
          in_val = 1'b0;                   // stall, no credit on hand
          @(posedge iclk);
          #1;
          w++;
        end
        if (in_creds == 0) begin
          stuck = 1'b1;
        end else begin
          rng = xorshift(rng);
          dat = rng[2:0];
          sop = (s == 0);
          eop = (s == len - 1);
          if (sop) st = 2'b00;               // frame restarts the trellis
          i_exp = axis_level({dat[3], dat[1]});  // point msb, subset msb
          q_exp = axis_level({dat[2], st[0]});   // point lsb, state bit
          st    = next_state(st, dat);
          exp_q.push_back({hold, sop, eop, tag, i_exp, q_exp});
          in_val = 1'b1;
          in_sop = sop;
          in_eop = eop;
          in_dat = dat;
          in_tag = sop ? tag : rng[TW+3:4];  // junk mid-frame, tag must hold
          @(posedge iclk);
          #1;
        end
      end
    end
    in_val = 1'b0;
    if (stuck) begin
      report_timeout("an input credit");
    end else begin
      w = 0;
      while ((rcv_cnt < total || ret_cnt < total) && w < TIMEOUT) begin
        @(posedge iclk);
        #1;
        w++;
      end
      if (rcv_cnt < total || ret_cnt < total) begin
        report_timeout("the pipeline to drain");
      end else begin
        for (w = 0; w < 4; w++) begin
          @(posedge iclk);                 // idle, any stray output shows up
        end
        #1;
        check_value("in_creds", `TCM_IN_DEPTH, in_creds);
        check_value("in_credit pulses", sent_cnt, crd_pulses);
        check_value("symbols received", total, rcv_cnt);
        check_value("symbols left in model", 0, exp_q.size());
        finish_run(1'b0);
      end
    end
  end

endmodule

//--- tb.f
+incdir+rtl
rtl/tcm_pkg.sv
rtl/tcm_credit_buffer.sv
rtl/tcm_trellis_enc.sv
rtl/tcm_qam16_mapper.sv
rtl/tcm_tx_top.sv
sim/tcm_tb.sv
